// ==== tankArena_consts.svh ====
`ifndef tankArenaConstsSvh
`define tankArenaConstsSvh

// Visible raster size
`define screenW 640
`define screenH 480

// Map geometry, 32 pixel tiles
`define tileShift 5
`define mapCols 20
`define mapRows 15

// Tank and bullet geometry
`define tankSize 24
`define bulletHalf 5
`define bulletStep 5
`define tankStartX 36
`define tankStartY 36
`define bulletParkXY 16

// Flat colours, 4 bits per channel
`define colEmpty 12'hFFF
`define colSolid 12'h888
`define colBrick 12'hA40
`define colCoin 12'hFF0
`define colTank 12'h0F0
`define colBullet 12'hF00
`define colBorder 12'h222

`endif

// ==== tankPkg.sv ====
`default_nettype none

package tankPkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixelPos_t;

    typedef struct packed {
        logic [4:0] col;
        logic [3:0] row;
    } tileIdx_t;

    // Codes match the level digits
    typedef enum logic [1:0] {tileEmpty, tileSolid, tileBrick, tileCoin} tileKind_t;

    typedef enum logic [1:0] {dirUp, dirDown, dirLeft, dirRight} dir_t;

    typedef struct packed {
        pixelPos_t pos;
        dir_t heading;
    } tankState_t;

    typedef struct packed {
        logic active;
        pixelPos_t pos;
        dir_t heading;
    } bulletState_t;

    typedef struct packed {
        logic valid;
        tileIdx_t idx;
    } tileClear_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

// ==== gameControl.sv ====
`default_nettype none
`include "tankArena_consts.svh"

module gameControl (
    input  wire logic                Master_Clock_In,
    input  wire logic                rstN,
    input  wire logic                dispEna,
    input  wire tankPkg::pixelPos_t  pixel,
    input  wire tankPkg::tileClear_t bulletClear,
    input  wire tankPkg::tileClear_t tankClear,
    output logic                     bulletTick,
    output logic                     tankTick,
    output tankPkg::tileClear_t      mapClear
);

    logic atEnd;
    logic atEndLast;
    logic frameEnd;

    // Frame end fires once on entry to the last pixel
    assign atEnd = dispEna && (pixel.x == tankPkg::coord_t'(`screenW))
                   && (pixel.y == tankPkg::coord_t'(`screenH));
    assign frameEnd = atEnd && !atEndLast;

    // Bullet phase first, then the tank phase
    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
        begin
            atEndLast  <= 1'b0;
            bulletTick <= 1'b0;
            tankTick   <= 1'b0;
        end
        else
        begin
            atEndLast  <= atEnd;
            bulletTick <= frameEnd;
            tankTick   <= bulletTick;
        end
    end

    // Single map write port goes to the active phase
    always_comb
    begin
        mapClear = '0;
        if (bulletTick)
            mapClear = bulletClear;
        else if (tankTick)
            mapClear = tankClear;
    end

    //////////////////////////////
    ticksApart: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        !(bulletTick && tankTick));

    // Requests outside their own phase would be dropped
    clearInTick: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        (!bulletClear.valid || bulletTick) && (!tankClear.valid || tankTick));

endmodule

`default_nettype wire

// ==== tileMap.sv ====
`default_nettype none
`include "tankArena_consts.svh"

module tileMap (
    input  wire logic                     Master_Clock_In,
    input  wire logic                     rstN,
    input  wire tankPkg::tileClear_t      mapClear,
    input  wire tankPkg::tileIdx_t        pixelIdx,
    input  wire tankPkg::tileIdx_t        bulletIdx,
    input  wire tankPkg::tileIdx_t [3:0]  cornerIdx,
    output tankPkg::tileKind_t            pixelTile,
    output tankPkg::tileKind_t            bulletTile,
    output tankPkg::tileKind_t [3:0]      cornerTiles
);

    // One hex digit per tile, column 0 leftmost
    localparam logic [79:0] levelRows [`mapRows] = '{
        80'h11101111111111110111,
        80'h10000000000000000001,
        80'h13111322300322311131,
        80'h10000020000002000001,
        80'h10222020111102022201,
        80'h10000020022002000001,
        80'h10100220022002200101,
        80'h00132332322323323100,
        80'h10100220022002200101,
        80'h10000020022002000001,
        80'h10222020111102022201,
        80'h10000020000002000001,
        80'h13111322300322311131,
        80'h10000000000000000001,
        80'h11101111111111110111
    };

    tankPkg::tileKind_t mapMem [`mapRows][`mapCols];

    // Anything outside the map reads as wall
    function automatic tankPkg::tileKind_t readTile(input tankPkg::tileIdx_t idx);
        if ((idx.col < `mapCols) && (idx.row < `mapRows))
            return mapMem[idx.row][idx.col];
        return tankPkg::tileSolid;
    endfunction

    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
        begin
            for (int r = 0; r < `mapRows; r++)
                for (int c = 0; c < `mapCols; c++)
                    mapMem[r][c] <= tankPkg::tileKind_t'(levelRows[r][77 - 4 * c -: 2]);
        end
        else if (mapClear.valid)
            mapMem[mapClear.idx.row][mapClear.idx.col] <= tankPkg::tileEmpty;
    end

    always_comb
    begin
        pixelTile  = readTile(pixelIdx);
        bulletTile = readTile(bulletIdx);
        for (int i = 0; i < 4; i++)
            cornerTiles[i] = readTile(cornerIdx[i]);
    end

    clearInMap: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        mapClear.valid |-> ((mapClear.idx.col < `mapCols) && (mapClear.idx.row < `mapRows)));

endmodule

`default_nettype wire

// ==== tankMover.sv ====
`default_nettype none
`include "tankArena_consts.svh"

module tankMover (
    input  wire logic                     Master_Clock_In,
    input  wire logic                     rstN,
    input  wire logic                     tankTick,
    input  wire logic                     btnUp,
    input  wire logic                     btnDown,
    input  wire logic                     btnLeft,
    input  wire logic                     btnRight,
    input  wire logic [1:0]               moveSpeed,
    input  wire tankPkg::tileKind_t [3:0] cornerTiles,
    output tankPkg::tileIdx_t [3:0]       cornerIdx,
    output tankPkg::tankState_t           tank,
    output tankPkg::tileClear_t           tankClear,
    output logic [7:0]                    coinCount
);

    tankPkg::coord_t    step;
    tankPkg::pixelPos_t nextPos;
    tankPkg::dir_t      newHeading;
    tankPkg::tileIdx_t  coinIdx;
    logic [10:0]        rightEdge;
    logic [10:0]        bottomEdge;
    logic               moving;
    logic               blocked;
    logic               hasCoin;

    assign step = tankPkg::coord_t'(moveSpeed) + 10'd1;

    //////////////////////////////
    // Proposed move, priority up right down left
    always_comb
    begin
        moving     = 1'b1;
        newHeading = tank.heading;
        nextPos    = tank.pos;
        if (btnUp)
        begin
            newHeading = tankPkg::dirUp;
            nextPos.y  = tank.pos.y - step;
        end
        else if (btnRight)
        begin
            newHeading = tankPkg::dirRight;
            nextPos.x  = tank.pos.x + step;
        end
        else if (btnDown)
        begin
            newHeading = tankPkg::dirDown;
            nextPos.y  = tank.pos.y + step;
        end
        else if (btnLeft)
        begin
            newHeading = tankPkg::dirLeft;
            nextPos.x  = tank.pos.x - step;
        end
        else
            moving = 1'b0;
    end

    // Wide edges catch wrap below zero as off screen
    assign rightEdge  = {1'b0, nextPos.x} + 11'(`tankSize);
    assign bottomEdge = {1'b0, nextPos.y} + 11'(`tankSize);

    assign cornerIdx[0] = '{col: nextPos.x[9:5], row: nextPos.y[8:5]};
    assign cornerIdx[1] = '{col: rightEdge[9:5], row: nextPos.y[8:5]};
    assign cornerIdx[2] = '{col: nextPos.x[9:5], row: bottomEdge[8:5]};
    assign cornerIdx[3] = '{col: rightEdge[9:5], row: bottomEdge[8:5]};

    // Walk backwards so top left wins the coin
    always_comb
    begin
        blocked = (rightEdge >= 11'(`screenW)) || (bottomEdge >= 11'(`screenH));
        hasCoin = 1'b0;
        coinIdx = cornerIdx[0];
        for (int i = 3; i >= 0; i--)
        begin
            if ((cornerTiles[i] == tankPkg::tileSolid) || (cornerTiles[i] == tankPkg::tileBrick))
                blocked = 1'b1;
            if (cornerTiles[i] == tankPkg::tileCoin)
            begin
                hasCoin = 1'b1;
                coinIdx = cornerIdx[i];
            end
        end
    end

    assign tankClear = '{valid: tankTick && moving && !blocked && hasCoin, idx: coinIdx};

    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
        begin
            tank.pos     <= '{x: tankPkg::coord_t'(`tankStartX), y: tankPkg::coord_t'(`tankStartY)};
            tank.heading <= tankPkg::dirUp;
            coinCount    <= 8'd0;
        end
        else if (tankTick && moving)
        begin
            // Heading turns even against a wall
            tank.heading <= newHeading;
            if (!blocked)
            begin
                tank.pos <= nextPos;
                if (hasCoin)
                    coinCount <= coinCount + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bulletEngine.sv ====
`default_nettype none
`include "tankArena_consts.svh"

module bulletEngine (
    input  wire logic                 Master_Clock_In,
    input  wire logic                 rstN,
    input  wire logic                 bulletTick,
    input  wire logic                 btnFire,
    input  wire tankPkg::tankState_t  tank,
    input  wire tankPkg::tileKind_t   bulletTile,
    output tankPkg::tileIdx_t         bulletIdx,
    output tankPkg::bulletState_t     bullet,
    output tankPkg::tileClear_t       bulletClear
);

    localparam tankPkg::coord_t halfTank   = tankPkg::coord_t'(`tankSize / 2);
    localparam tankPkg::coord_t muzzle     = tankPkg::coord_t'(`tankSize / 2 + 6);
    localparam tankPkg::coord_t flightStep = tankPkg::coord_t'(`bulletStep);
    localparam tankPkg::coord_t parkXY     = tankPkg::coord_t'(`bulletParkXY);

    tankPkg::pixelPos_t spawnPos;
    tankPkg::pixelPos_t advPos;
    logic               fireLast;
    logic               spawn;
    logic               offScreen;
    logic               hitBrick;
    logic               stop;

    // Fire edge measured between ticks
    assign spawn = btnFire && !fireLast && !bullet.active;

    assign offScreen = (bullet.pos.x >= tankPkg::coord_t'(`screenW))
                       || (bullet.pos.y >= tankPkg::coord_t'(`screenH));
    assign bulletIdx = '{col: bullet.pos.x[9:5], row: bullet.pos.y[8:5]};
    assign hitBrick  = !offScreen && (bulletTile == tankPkg::tileBrick);
    assign stop      = offScreen || hitBrick || (bulletTile == tankPkg::tileSolid);

    assign bulletClear = '{valid: bulletTick && bullet.active && hitBrick, idx: bulletIdx};

    //////////////////////////////
    always_comb
    begin
        spawnPos = '{x: tank.pos.x + halfTank, y: tank.pos.y + halfTank};
        advPos   = bullet.pos;
        case (tank.heading)
            tankPkg::dirUp:    spawnPos.y = spawnPos.y - muzzle;
            tankPkg::dirDown:  spawnPos.y = spawnPos.y + muzzle;
            tankPkg::dirLeft:  spawnPos.x = spawnPos.x - muzzle;
            default:           spawnPos.x = spawnPos.x + muzzle;
        endcase
        case (bullet.heading)
            tankPkg::dirUp:    advPos.y = bullet.pos.y - flightStep;
            tankPkg::dirDown:  advPos.y = bullet.pos.y + flightStep;
            tankPkg::dirLeft:  advPos.x = bullet.pos.x - flightStep;
            default:           advPos.x = bullet.pos.x + flightStep;
        endcase
    end

    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
        begin
            fireLast       <= 1'b0;
            bullet.active  <= 1'b0;
            bullet.pos     <= '{x: parkXY, y: parkXY};
            bullet.heading <= tankPkg::dirUp;
        end
        else if (bulletTick)
        begin
            fireLast <= btnFire;
            if (spawn)
            begin
                bullet.active  <= 1'b1;
                bullet.pos     <= spawnPos;
                bullet.heading <= tank.heading;
            end
            else if (bullet.active)
            begin
                if (stop)
                begin
                    bullet.active <= 1'b0;
                    bullet.pos    <= '{x: parkXY, y: parkXY};
                end
                else
                    bullet.pos <= advPos;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pixelPainter.sv ====
`default_nettype none
`include "tankArena_consts.svh"

module pixelPainter (
    input  wire logic                  Master_Clock_In,
    input  wire logic                  rstN,
    input  wire logic                  dispEna,
    input  wire tankPkg::pixelPos_t    pixel,
    input  wire tankPkg::tankState_t   tank,
    input  wire tankPkg::bulletState_t bullet,
    input  wire tankPkg::tileKind_t    pixelTile,
    output tankPkg::tileIdx_t          pixelIdx,
    output tankPkg::rgb_t              colour
);

    tankPkg::rgb_t tileColour;
    tankPkg::rgb_t nextColour;
    logic          visible;
    logic          inTank;
    logic          inBullet;

    // Strictly between the box edges
    function automatic logic insideBox(input tankPkg::coord_t p, input tankPkg::coord_t lo);
        logic [10:0] pw;
        pw = {1'b0, p};
        return (p > lo) && (pw < {1'b0, lo} + 11'(`tankSize));
    endfunction

    function automatic logic nearCentre(input tankPkg::coord_t p, input tankPkg::coord_t c);
        logic [10:0] pw;
        logic [10:0] cw;
        pw = {1'b0, p};
        cw = {1'b0, c};
        return (pw + 11'(`bulletHalf) >= cw) && (pw <= cw + 11'(`bulletHalf));
    endfunction

    assign pixelIdx = '{col: pixel.x[9:5], row: pixel.y[8:5]};
    assign visible  = (pixel.x < tankPkg::coord_t'(`screenW))
                      && (pixel.y < tankPkg::coord_t'(`screenH));
    assign inTank   = insideBox(pixel.x, tank.pos.x) && insideBox(pixel.y, tank.pos.y);
    assign inBullet = bullet.active && nearCentre(pixel.x, bullet.pos.x)
                      && nearCentre(pixel.y, bullet.pos.y);

    always_comb
    begin
        case (pixelTile)
            tankPkg::tileSolid: tileColour = `colSolid;
            tankPkg::tileBrick: tileColour = `colBrick;
            tankPkg::tileCoin:  tileColour = `colCoin;
            default:            tileColour = `colEmpty;
        endcase
        if (!dispEna)
            nextColour = '0;
        else if (!visible)
            nextColour = `colBorder;
        else if (inTank)
            nextColour = `colTank;
        else if (inBullet)
            nextColour = `colBullet;
        else
            nextColour = tileColour;
    end

    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
            colour <= '0;
        else
            colour <= nextColour;
    end

endmodule

`default_nettype wire

// ==== tankArena.sv ====
`default_nettype none

module tankArena (
    input  wire logic               Master_Clock_In,
    input  wire logic               rstN,
    input  wire logic               dispEna,
    input  wire tankPkg::pixelPos_t pixel,
    input  wire logic               btnUp,
    input  wire logic               btnDown,
    input  wire logic               btnLeft,
    input  wire logic               btnRight,
    input  wire logic               btnFire,
    input  wire logic [1:0]         moveSpeed,
    output tankPkg::rgb_t           colour,
    output logic [7:0]              coinCount
);

    logic                     bulletTick;
    logic                     tankTick;
    tankPkg::tileClear_t      bulletClear;
    tankPkg::tileClear_t      tankClear;
    tankPkg::tileClear_t      mapClear;
    tankPkg::tileIdx_t        pixelIdx;
    tankPkg::tileIdx_t        bulletIdx;
    tankPkg::tileIdx_t [3:0]  cornerIdx;
    tankPkg::tileKind_t       pixelTile;
    tankPkg::tileKind_t       bulletTile;
    tankPkg::tileKind_t [3:0] cornerTiles;
    tankPkg::tankState_t      tank;
    tankPkg::bulletState_t    bullet;

    //////////////////////////////
    // Frame sequencing and map
    gameControl gameControlInst (
        .Master_Clock_In, .rstN, .dispEna, .pixel,
        .bulletClear, .tankClear, .bulletTick, .tankTick, .mapClear
    );

    tileMap tileMapInst (
        .Master_Clock_In, .rstN, .mapClear, .pixelIdx, .bulletIdx, .cornerIdx,
        .pixelTile, .bulletTile, .cornerTiles
    );

    //////////////////////////////
    // Game objects and drawing
    tankMover tankMoverInst (
        .Master_Clock_In, .rstN, .tankTick,
        .btnUp, .btnDown, .btnLeft, .btnRight, .moveSpeed,
        .cornerTiles, .cornerIdx, .tank, .tankClear, .coinCount
    );

    bulletEngine bulletEngineInst (
        .Master_Clock_In, .rstN, .bulletTick, .btnFire, .tank, .bulletTile,
        .bulletIdx, .bullet, .bulletClear
    );

    pixelPainter pixelPainterInst (
        .Master_Clock_In, .rstN, .dispEna, .pixel, .tank, .bullet, .pixelTile,
        .pixelIdx, .colour
    );

endmodule

`default_nettype wire

// ==== tb_tankArena.sv ====
`default_nettype none
`include "tankArena_consts.svh"

module tb_tankArena;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxFrames  = 64;
    localparam int maxRecords = 256;
    localparam int simLimit   = 1000000;

    logic               Master_Clock_In;
    logic               rstN;
    logic               dispEna;
    tankPkg::pixelPos_t pixel;
    logic               btnUp;
    logic               btnDown;
    logic               btnLeft;
    logic               btnRight;
    logic               btnFire;
    logic [1:0]         moveSpeed;
    tankPkg::rgb_t      colour;
    logic [7:0]         coinCount;

    int checkCount;
    int failCount;

    tankArena tankArena_inst (
        .Master_Clock_In, .rstN, .dispEna, .pixel,
        .btnUp, .btnDown, .btnLeft, .btnRight, .btnFire, .moveSpeed,
        .colour, .coinCount
    );

    initial
    begin
        Master_Clock_In = 1'b0;
        forever
            #10 Master_Clock_In = ~Master_Clock_In;
    end

    // Hard stop if the record sequence never ends
    initial
    begin
        #(simLimit);
        $display("Simulation ran past %0d ns without finishing the test records", simLimit);
        $display("TESTS FAILED");
        $finish;
    end

    // Any visible pixel, never the frame-end position
    function automatic tankPkg::pixelPos_t randomPixel();
        tankPkg::pixelPos_t p;
        p.x = tankPkg::coord_t'($urandom % `screenW);
        p.y = tankPkg::coord_t'($urandom % `screenH);
        return p;
    endfunction

    task automatic compareValue(input int behavior, input string name,
                                input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        if (got !== want)
        begin
            failCount++;
            $display("FAIL behavior %0d %s: got 0x%h, expected 0x%h", behavior, name, got, want);
        end
        else
            $display("ok   behavior %0d %s = 0x%h", behavior, name, got);
    endtask

    task automatic reportBadRecord(input string line);
        failCount++;
        $display("Malformed test data record: %s", line);
    endtask

    //////////////////////////////
    // Raster driving

    task automatic idleCycles(input int count);
        for (int i = 0; i < count; i++)
        begin
            @(posedge Master_Clock_In);
            dispEna <= 1'b1;
            pixel   <= randomPixel();
        end
    endtask

    task automatic runFrames(input int frames);
        int limited;
        limited = frames;
        if (frames > maxFrames)
        begin
            failCount++;
            $display("Frame count %0d is above the limit of %0d frames", frames, maxFrames);
            limited = maxFrames;
        end
        for (int f = 0; f < limited; f++)
        begin
            @(posedge Master_Clock_In);
            dispEna <= 1'b1;
            pixel   <= '{x: tankPkg::coord_t'(`screenW), y: tankPkg::coord_t'(`screenH)};
            // Bullet tick, tank tick, then settled state
            idleCycles(4);
        end
    endtask

    task automatic probePixel(input int behavior, input int ena, input int x, input int y,
                              input int want);
        @(posedge Master_Clock_In);
        dispEna <= (ena != 0);
        pixel   <= '{x: tankPkg::coord_t'(x), y: tankPkg::coord_t'(y)};
        @(posedge Master_Clock_In);
        dispEna <= 1'b1;
        pixel   <= randomPixel();
        // Colour lags the raster by one clock
        @(negedge Master_Clock_In);
        compareValue(behavior, $sformatf("colour at (%0d, %0d)", x, y), 32'(colour), want);
    endtask

    //////////////////////////////
    // Test record interpreter

    task automatic runRecords(input int fd);
        string line;
        string rest;
        byte   kind;
        int    records;
        int    v0;
        int    v1;
        int    v2;
        int    v3;
        int    v4;
        int    v5;
        records = 0;
        while (records < maxRecords)
        begin
            if ($fgets(line, fd) == 0)
                break;
            kind = line.getc(0);
            if ((line.len() < 3) || (kind == "#"))
                continue;
            records++;
            rest = line.substr(2, line.len() - 1);
            case (kind)
                "B":
                begin
                    if ($sscanf(rest, "%d %d %d %d %d %d", v0, v1, v2, v3, v4, v5) == 6)
                    begin
                        @(posedge Master_Clock_In);
                        btnUp     <= (v0 != 0);
                        btnDown   <= (v1 != 0);
                        btnLeft   <= (v2 != 0);
                        btnRight  <= (v3 != 0);
                        btnFire   <= (v4 != 0);
                        moveSpeed <= 2'(v5);
                    end
                    else
                        reportBadRecord(line);
                end
                "F":
                begin
                    if ($sscanf(rest, "%d", v0) == 1)
                        runFrames(v0);
                    else
                        reportBadRecord(line);
                end
                "P":
                begin
                    if ($sscanf(rest, "%d %d %d %d %h", v0, v1, v2, v3, v4) == 5)
                        probePixel(v0, v1, v2, v3, v4);
                    else
                        reportBadRecord(line);
                end
                "C":
                begin
                    if ($sscanf(rest, "%d %d", v0, v1) == 2)
                    begin
                        @(negedge Master_Clock_In);
                        compareValue(v0, "coinCount", 32'(coinCount), v1);
                    end
                    else
                        reportBadRecord(line);
                end
                default:
                    reportBadRecord(line);
            endcase
        end
        if (records >= maxRecords)
        begin
            failCount++;
            $display("Test data holds more than %0d records", maxRecords);
        end
    endtask

    initial
    begin
        int fd;
        void'($urandom(96));
        checkCount = 0;
        failCount  = 0;
        rstN       = 1'b0;
        dispEna    = 1'b0;
        pixel      = '0;
        btnUp      = 1'b0;
        btnDown    = 1'b0;
        btnLeft    = 1'b0;
        btnRight   = 1'b0;
        btnFire    = 1'b0;
        moveSpeed  = 2'd0;
        for (int i = 0; i < 16; i++)
            @(posedge Master_Clock_In);
        rstN <= 1'b1;

        fd = $fopen("tankArena_testdata.txt", "r");
        if (fd == 0)
        begin
            failCount++;
            $display("Could not open tankArena_testdata.txt for reading");
        end
        else
        begin
            runRecords(fd);
            $fclose(fd);
        end
        if (checkCount == 0)
        begin
            failCount++;
            $display("No checks were run");
        end

        $display("%0d checks run, %0d failures", checkCount, failCount);
        if (failCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tankArena_testdata.txt ====
# B up down left right fire speed | F frames | P behavior dispEna x y colour(hex)
# C behavior coinCount | lines starting with # are skipped
P 1 0 100 100 000
P 1 1 700 100 222
P 2 1 16 16 888
P 2 1 62 62 fff
P 2 1 48 80 ff0
P 2 1 208 112 a40
B 0 0 0 1 0 1
F 3
P 3 1 44 48 0f0
P 3 1 40 48 fff
B 1 0 0 0 0 1
F 10
P 4 1 48 33 0f0
P 4 1 48 32 fff
P 4 1 48 20 888
# Line up with the coin column, then drive down onto it
B 0 0 1 0 0 1
F 2
B 0 1 0 0 0 1
F 3
C 5 0
F 1
C 5 1
P 5 1 48 80 fff
# Down into tile row 3, turn right against the wall, then fire at the brick
B 0 1 0 0 0 3
F 12
B 0 0 0 1 0 3
F 1
P 6 1 61 100 0f0
P 6 1 62 100 fff
B 0 0 0 0 1 3
F 1
B 0 0 0 0 0 3
F 1
B 0 0 0 0 1 3
F 1
B 0 0 0 0 0 3
P 6 1 78 100 f00
P 6 1 68 100 fff
F 23
P 6 1 208 112 a40
F 1
P 6 1 208 112 fff
C 6 1

// ==== compile.f ====
+incdir+.
tankPkg.sv
gameControl.sv
tileMap.sv
tankMover.sv
bulletEngine.sv
pixelPainter.sv
tankArena.sv
tb_tankArena.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_tankArena \
    -f compile.f -o tb_tankArena \
    && ./obj_dir/tb_tankArena > sim.log 2>&1 \
    || echo "build or run stopped early" >> sim.log

cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
